//--- filelist.f
+incdir+include
source/spi_master_pkg.sv
source/spi_queue.sv
source/spi_shift_engine.sv
source/spi_master_regs.sv
source/spi_master.sv
dv/spi_master_assert.sv
dv/spi_master_checker.sv
dv/spi_master_tb.sv

//--- dv/spi_master_tb.sv
/* spi master testbench
   random emesh traffic with miso looped back to mosi,
   checker and bound assertions watch the DUT */
`timescale 1ns/1ps
`include "spi_master_macros.svh"

module spi_master_tb;

   import spi_master_pkg::*;

   localparam int     num_rounds    = 24;
   localparam int     max_req_round = 34; // upper bound per round
   localparam int     num_req       = num_rounds * max_req_round;
   localparam longint timeout_ns    = 2 * num_req * 16 * 256 * 4; // worst case frames

   logic          clk;
   logic          nreset;
   logic          hw_en;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;
   logic          sclk;
   logic          mosi;
   logic          ss_n;
   logic          miso;
   int            reads_issued;
   int            check_errors;
   int            responses;
   int            pending;
   int            assert_fails;

   assign miso = mosi; // loopback, every rx byte equals the tx byte

   spi_master u_spi_master (
      .clk        (clk),
      .nreset     (nreset),
      .hw_en      (hw_en),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss_n       (ss_n),
      .miso       (miso)
   );

   spi_master_checker u_checker (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .errors     (check_errors),
      .responses  (responses),
      .pending    (pending)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns period
   end

   // ################################################
   // stimulus helpers
   // ################################################

   // hold the request until wait_out lets it through
   task automatic issue_request(input logic wr, input logic [5:0] off,
                                input logic [31:0] data);
      emesh_packet_t pkt;
      logic [31:0]   upper;
      upper        = $urandom;
      pkt.write    = wr;
      pkt.datamode = 2'($urandom_range(3));
      pkt.ctrlmode = 5'($urandom_range(31));
      pkt.dstaddr  = {upper[`SPI_AW-1:6], off}; // only low bits decode
      pkt.srcaddr  = $urandom;
      pkt.data     = data;
      @(negedge clk);
      while (wait_out)
         @(negedge clk);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      @(negedge clk);
      while (wait_out)
         @(negedge clk);
      @(posedge clk); // accepted here
      access_in <= 1'b0;
      if (!wr)
         reads_issued++;
   endtask

   // reads that are safe while a frame runs
   function automatic logic [5:0] pick_busy_offset();
      case ($urandom_range(5))
         0       : return `SPI_CONFIG;
         1       : return `SPI_CLKDIV;
         2       : return `SPI_CMD;
         3       : return `SPI_TX;  // write only, reads as a miss
         4       : return 6'h3f;
         default : return 6'h1a;
      endcase
   endfunction

   // idle once ss_n has stayed high long enough to drain the queue
   task automatic wait_engine_idle();
      int quiet;
      quiet = 0;
      while (quiet < 8)
      begin
         @(negedge clk);
         if (ss_n)
            quiet++;
         else
            quiet = 0;
      end
   endtask

   task automatic drive_back_pressure();
      forever
      begin
         @(posedge clk);
         wait_in <= ($urandom_range(3) == 0); // stall about a quarter of cycles
      end
   endtask

   task automatic run_round();
      int n_bytes;
      issue_request(1'b0, `SPI_CONFIG, $urandom); // reset values in round 0
      issue_request(1'b0, `SPI_CLKDIV, $urandom);
      // engine idle here, so mode changes are safe
      issue_request(1'b1, `SPI_CONFIG, $urandom & 32'hffff_fffe); // keep enabled
      issue_request(1'b1, `SPI_CLKDIV, ($urandom & 32'hffff_ff00) | $urandom_range(7));
      if ($urandom_range(1) == 1)
      begin
         issue_request(1'b1, `SPI_STATUS, $urandom);
         issue_request(1'b0, `SPI_STATUS, $urandom); // rx flag follows the write
      end
      n_bytes = $urandom_range(12, 1); // above 8 fills the tx queue
      for (int i = 0; i < n_bytes; i++)
      begin
         if ($urandom_range(3) == 0)
            issue_request(1'b0, pick_busy_offset(), $urandom);
         issue_request(1'b1, `SPI_TX, $urandom);
      end
      wait_engine_idle();
      issue_request(1'b0, `SPI_RX0, $urandom);
      issue_request(1'b0, `SPI_RX1, $urandom);
      issue_request(1'b0, `SPI_STATUS, $urandom);
      issue_request(1'b0, pick_busy_offset(), $urandom);
   endtask

   // ################################################
   // main sequence
   // ################################################
   initial
   begin
      void'($urandom(70538));
      reads_issued = 0;
      nreset    <= 1'b0;
      hw_en     <= 1'b1;
      access_in <= 1'b0;
      packet_in <= '0;
      wait_in   <= 1'b0;
      repeat (8) @(posedge clk);
      nreset <= 1'b1;
      fork
         drive_back_pressure();
      join_none
      for (int r = 0; r < num_rounds; r++)
         run_round();
      while (pending != 0) // drain under random stalls
         @(negedge clk);
      repeat (8) @(negedge clk); // room for a stray extra response
      assert_fails = u_spi_master.u_assert.fail_count;
      $display("responses %0d of %0d reads, data errors %0d, assertion failures %0d",
               responses, reads_issued, check_errors, assert_fails);
      if ((check_errors == 0) && (assert_fails == 0) && (responses == reads_issued))
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // watchdog
   initial
   begin
      #(timeout_ns);
      $display("timeout: the run did not finish within %0d ns, %0d reads unanswered",
               timeout_ns, pending);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- dv/spi_master_checker.sv
/* spi master response checker
   models the register file and the looped back rx data,
   compares every response packet in request order */
`timescale 1ns/1ps
`include "spi_master_macros.svh"

module spi_master_checker (
   input  logic                          clk,
   input  logic                          nreset,
   input  logic                          access_in,
   input  spi_master_pkg::emesh_packet_t packet_in,
   input  logic                          wait_out,
   input  logic                          access_out,
   input  spi_master_pkg::emesh_packet_t packet_out,
   output int                            errors,
   output int                            responses, // packets compared
   output int                            pending    // reads not yet answered
);

   import spi_master_pkg::*;

   emesh_packet_t exp_q[$]; // expected responses, oldest first
   logic [7:0]    config_m;
   logic [7:0]    clkdiv_m;
   logic          rx_flag;  // sticky received flag
   logic [63:0]   rx_hist;  // last eight bytes sent, newest low

   // ################################################
   // register model
   // ################################################

   // rx and status are only read once the engine has gone idle
   function automatic logic [31:0] model_read(input logic [5:0] off);
      logic [31:0] value;
      case (off)
         `SPI_CONFIG : value = {24'b0, config_m};
         `SPI_STATUS : value = {29'b0, 2'b00, rx_flag}; // queue empty, not busy
         `SPI_CLKDIV : value = {24'b0, clkdiv_m};
         `SPI_RX0    : value = rx_hist[31:0];
         `SPI_RX1    : value = rx_hist[63:32];
         default     : value = `SPI_READ_MISS; // cmd, tx and holes
      endcase
      return value;
   endfunction

   task automatic apply_request(input emesh_packet_t req);
      emesh_packet_t rsp;
      logic [5:0]    off;
      off = req.dstaddr[5:0];
      if (req.write)
      begin
         case (off)
            `SPI_CONFIG : config_m = req.data[7:0];
            `SPI_CLKDIV : clkdiv_m = req.data[7:0];
            `SPI_STATUS : rx_flag = req.data[0];
            `SPI_TX :
            begin
               rx_hist = {rx_hist[55:0], req.data[7:0]}; // comes back on miso
               rx_flag = 1'b1;
            end
            default : ;
         endcase
      end
      else
      begin
         rsp.write    = 1'b1;
         rsp.datamode = req.datamode;
         rsp.ctrlmode = req.ctrlmode;
         rsp.dstaddr  = req.srcaddr; // back to the requester
         rsp.srcaddr  = '0;
         rsp.data     = model_read(off);
         exp_q.push_back(rsp);
      end
   endtask

   // ################################################
   // response compare
   // ################################################
   task automatic compare_response(input emesh_packet_t got);
      emesh_packet_t exp;
      if (exp_q.size() == 0)
      begin
         errors++;
         $display("error at %0t ns: response with no outstanding read, dstaddr %h",
                  $time, got.dstaddr);
      end
      else
      begin
         exp = exp_q.pop_front();
         responses++;
         if (got !== exp)
         begin
            errors++;
            $display("error at %0t ns: response %0d got w %b dst %h src %h mode %h/%h data %h",
                     $time, responses, got.write, got.dstaddr, got.srcaddr,
                     got.ctrlmode, got.datamode, got.data);
            $display("error at %0t ns: response %0d exp w %b dst %h src %h mode %h/%h data %h",
                     $time, responses, exp.write, exp.dstaddr, exp.srcaddr,
                     exp.ctrlmode, exp.datamode, exp.data);
         end
      end
   endtask

   // inputs change on rising edges, so sample on falling ones
   always @(negedge clk)
   begin
      if (!nreset)
      begin
         config_m  = '0;
         clkdiv_m  = `SPI_CLKDIV_RESET;
         rx_flag   = 1'b0;
         rx_hist   = '0;
         errors    = 0;
         responses = 0;
         exp_q.delete();
      end
      else
      begin
         if (access_out) // popped on the next edge
            compare_response(packet_out);
         if (access_in && !wait_out) // accepted on the next edge
            apply_request(packet_in);
      end
      pending = exp_q.size();
   end

endmodule

//--- dv/spi_master_assert.sv
/* spi master protocol assertions
   bound into the top level, checks reset state and queue handshakes */
`timescale 1ns/1ps

module spi_master_assert (
   input logic                          clk,
   input logic                          nreset,
   input logic                          access_out,
   input logic                          wait_out,
   input logic                          wait_in,
   input logic                          ss_n,
   input logic                          sclk,
   input logic                          cpol,       // internal, engine config
   input logic                          tx_push,    // internal, tx queue write
   input logic                          tx_full,
   input logic                          rsp_push,   // internal, response queue write
   input logic                          rsp_full,
   input logic                          rsp_nempty, // internal, response queue flag
   input spi_master_pkg::emesh_packet_t packet_out
);

   int fail_count = 0; // failures seen so far

   // outputs parked while reset is held, cpol is 0 there
   reset_outputs : assert property (@(posedge clk)
      !nreset |-> (!access_out && !wait_out && ss_n && !sclk))
   else
   begin
      fail_count++;
      $error("outputs not at their reset values while reset is held");
   end

   // first edge out of reset
   reset_release : assert property (@(posedge clk)
      $rose(nreset) |-> (!access_out && !wait_out && ss_n))
   else
   begin
      fail_count++;
      $error("outputs not at their reset values on reset release");
   end

   // wait_out must keep both queues from overflowing
   tx_no_overflow : assert property (@(posedge clk) disable iff (!nreset)
      !(tx_push && tx_full))
   else
   begin
      fail_count++;
      $error("tx queue pushed while full");
   end

   rsp_no_overflow : assert property (@(posedge clk) disable iff (!nreset)
      !(rsp_push && rsp_full))
   else
   begin
      fail_count++;
      $error("response queue pushed while full");
   end

   // a stalled head stays put until the core takes it
   stall_holds : assert property (@(posedge clk) disable iff (!nreset)
      (wait_in && rsp_nempty) |=> (rsp_nempty && $stable(packet_out)))
   else
   begin
      fail_count++;
      $error("response head changed or vanished while wait_in is high");
   end

   // between frames sclk parks at cpol, one cycle late after a change
   idle_level : assert property (@(posedge clk) disable iff (!nreset)
      (ss_n && $stable(cpol)) |-> (sclk == cpol))
   else
   begin
      fail_count++;
      $error("sclk not at its idle level while ss_n is high");
   end

endmodule

bind spi_master spi_master_assert u_assert (
   .clk        (clk),
   .nreset     (nreset),
   .access_out (access_out),
   .wait_out   (wait_out),
   .wait_in    (wait_in),
   .ss_n       (ss_n),
   .sclk       (sclk),
   .cpol       (cfg.cpol),
   .tx_push    (tx_push),
   .tx_full    (tx_full),
   .rsp_push   (rsp_push),
   .rsp_full   (rsp_full),
   .rsp_nempty (rsp_nempty),
   .packet_out (packet_out)
);

//--- source/spi_master.sv
/* spi master top level
   register file, tx byte queue, response queue and shift engine */
`timescale 1ns/1ps
`include "spi_master_macros.svh"

module spi_master (
   input  logic                          clk,
   input  logic                          nreset,
   input  logic                          hw_en,
   // requests from the core
   input  logic                          access_in,
   input  spi_master_pkg::emesh_packet_t packet_in,
   output logic                          wait_out,
   // responses to the core
   output logic                          access_out,
   output spi_master_pkg::emesh_packet_t packet_out,
   input  logic                          wait_in,
   // spi pins
   output logic                          sclk,
   output logic                          mosi,
   output logic                          ss_n,
   input  logic                          miso
);

   import spi_master_pkg::*;

   logic          tx_push;
   logic [7:0]    tx_wbyte;   // regs to queue
   logic [7:0]    tx_head;    // queue to engine
   logic          tx_pop;
   logic          tx_full;
   logic          tx_nempty;
   logic          rsp_push;
   emesh_packet_t rsp_packet;
   logic          rsp_full;
   logic          rsp_nempty;
   spi_cfg_t      cfg;
   spi_state_t    spi_state;
   logic          rx_access;
   logic [7:0]    rx_byte;

   // head leaves whenever the core is not stalling
   assign access_out = rsp_nempty & ~wait_in;

   // ################################################
   // input side
   // ################################################
   spi_master_regs u_regs (
      .clk        (clk),
      .nreset     (nreset),
      .hw_en      (hw_en),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .tx_full    (tx_full),
      .rsp_full   (rsp_full),
      .tx_nempty  (tx_nempty),
      .tx_push    (tx_push),
      .tx_byte    (tx_wbyte),
      .rsp_push   (rsp_push),
      .rsp_packet (rsp_packet),
      .cfg        (cfg),
      .spi_state  (spi_state),
      .rx_access  (rx_access),
      .rx_byte    (rx_byte)
   );

   spi_queue #(
      .entry_t (logic [7:0]),
      .depth   (`SPI_TX_DEPTH)
   ) u_tx_queue (
      .clk    (clk),
      .nreset (nreset),
      .push   (tx_push),
      .din    (tx_wbyte),
      .pop    (tx_pop),
      .dout   (tx_head),
      .nempty (tx_nempty),
      .full   (tx_full)
   );

   // processing part
   spi_shift_engine u_engine (
      .clk       (clk),
      .nreset    (nreset),
      .cfg       (cfg),
      .tx_nempty (tx_nempty),
      .tx_pop    (tx_pop),
      .tx_byte   (tx_head),
      .state     (spi_state),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss_n      (ss_n),
      .miso      (miso),
      .rx_access (rx_access),
      .rx_byte   (rx_byte)
   );

   // output side
   spi_queue #(
      .entry_t (emesh_packet_t),
      .depth   (`SPI_RSP_DEPTH)
   ) u_rsp_queue (
      .clk    (clk),
      .nreset (nreset),
      .push   (rsp_push),
      .din    (rsp_packet),
      .pop    (access_out),
      .dout   (packet_out),
      .nempty (rsp_nempty),
      .full   (rsp_full)
   );

endmodule

//--- source/spi_master_regs.sv
/* spi master register file
   decodes emesh requests, holds config, status, clkdiv and rx registers,
   pushes tx bytes and builds read response packets */
`timescale 1ns/1ps
`include "spi_master_macros.svh"

module spi_master_regs (
   input  logic                          clk,
   input  logic                          nreset,
   input  logic                          hw_en,     // block enable pin
   // request side
   input  logic                          access_in,
   input  spi_master_pkg::emesh_packet_t packet_in,
   output logic                          wait_out,
   // queue flags
   input  logic                          tx_full,
   input  logic                          rsp_full,
   input  logic                          tx_nempty,
   // tx queue push
   output logic                          tx_push,
   output logic [7:0]                    tx_byte,
   // response queue push
   output logic                          rsp_push,
   output spi_master_pkg::emesh_packet_t rsp_packet,
   // shift engine
   output spi_master_pkg::spi_cfg_t      cfg,
   input  spi_master_pkg::spi_state_t    spi_state,
   input  logic                          rx_access, // one cycle per byte
   input  logic [7:0]                    rx_byte
);

   import spi_master_pkg::*;

   logic [7:0]  config_reg;
   logic [7:0]  clkdiv_reg;
   spi_status_t status_reg;
   logic [63:0] rx_reg;       // last eight bytes, newest low
   logic        accept;
   logic        req_write;
   logic        req_read;
   logic [5:0]  offset;
   logic        config_write;
   logic        status_write;
   logic        clkdiv_write;
   logic [31:0] rd_data;

   // ################################################
   // request decode
   // ################################################

   // a read in flight to the response queue counts as occupied,
   // so back-to-back reads cannot overrun a nearly full queue
   assign wait_out = tx_full | rsp_full | rsp_push;

   assign accept    = access_in & ~wait_out;
   assign req_write = accept & packet_in.write;
   assign req_read  = accept & ~packet_in.write;
   assign offset    = packet_in.dstaddr[5:0];

   assign config_write = req_write & (offset == `SPI_CONFIG);
   assign status_write = req_write & (offset == `SPI_STATUS);
   assign clkdiv_write = req_write & (offset == `SPI_CLKDIV);

   // tx write goes straight to the queue, lands on the next edge
   assign tx_push = req_write & (offset == `SPI_TX);
   assign tx_byte = packet_in.data[7:0];

   // ################################################
   // config and clkdiv
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         config_reg <= '0;
         clkdiv_reg <= `SPI_CLKDIV_RESET;
      end
      else
      begin
         if (config_write)
            config_reg <= packet_in.data[7:0];
         if (clkdiv_write)
            clkdiv_reg <= packet_in.data[7:0];
      end
   end

   // config bit 0 disables, bit 1 is irq_en (stored only)
   assign cfg.spi_en   = hw_en & ~config_reg[0];
   assign cfg.cpol     = config_reg[2];
   assign cfg.cpha     = config_reg[3];
   assign cfg.lsbfirst = config_reg[4];
   assign cfg.clkdiv   = clkdiv_reg;

   // ################################################
   // status
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         status_reg <= '0;
      else if (status_write)
         status_reg <= packet_in.data[7:0]; // software clears rx_done here
      else
      begin
         status_reg.rsvd      <= '0;
         status_reg.tx_nempty <= tx_nempty;
         status_reg.busy      <= (spi_state != spi_idle);
         status_reg.rx_done   <= status_reg.rx_done | rx_access; // sticky
      end
   end

   // rx bytes enter at the bottom, older ones move up
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rx_reg <= '0;
      else if (rx_access)
         rx_reg <= {rx_reg[55:0], rx_byte};
   end

   // ################################################
   // readback and response packet
   // ################################################
   always_comb
   begin
      case (offset)
         `SPI_CONFIG : rd_data = {24'b0, config_reg};
         `SPI_STATUS : rd_data = {24'b0, status_reg};
         `SPI_CLKDIV : rd_data = {24'b0, clkdiv_reg};
         `SPI_RX0    : rd_data = rx_reg[31:0];
         `SPI_RX1    : rd_data = rx_reg[63:32];
         default     : rd_data = `SPI_READ_MISS; // cmd, tx and holes
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rsp_push <= 1'b0;
      else
         rsp_push <= req_read; // one edge after acceptance
   end

   // reply to the requester, routing fields copied
   always_ff @(posedge clk)
   begin
      if (req_read)
      begin
         rsp_packet.write    <= 1'b1;
         rsp_packet.datamode <= packet_in.datamode;
         rsp_packet.ctrlmode <= packet_in.ctrlmode;
         rsp_packet.dstaddr  <= packet_in.srcaddr;
         rsp_packet.srcaddr  <= '0;
         rsp_packet.data     <= rd_data;
      end
   end

endmodule

//--- source/spi_shift_engine.sv
/* spi shift engine
   pops queued bytes and runs one frame each on sclk, mosi and ss_n,
   collects miso into a byte and pulses rx_access when the frame ends */
`timescale 1ns/1ps

module spi_shift_engine (
   input  logic                       clk,
   input  logic                       nreset,
   input  spi_master_pkg::spi_cfg_t   cfg,
   // tx queue
   input  logic                       tx_nempty,
   output logic                       tx_pop,
   input  logic [7:0]                 tx_byte,   // queue head
   output spi_master_pkg::spi_state_t state,
   // spi pins
   output logic                       sclk,
   output logic                       mosi,
   output logic                       ss_n,
   input  logic                       miso,
   // received byte
   output logic                       rx_access,
   output logic [7:0]                 rx_byte
);

   import spi_master_pkg::*;

   logic [7:0] div_cnt;     // counts one half period
   logic       tick;        // last cycle of a half period
   logic [2:0] bit_cnt;
   logic       second_half; // next tick is the trailing edge
   logic       lead_edge;
   logic       trail_edge;
   logic       sample;      // capture miso
   logic       advance;     // next bit onto mosi
   logic [7:0] tx_sr;
   logic [7:0] rx_sr;

   assign tick       = (div_cnt == cfg.clkdiv);
   assign lead_edge  = (state == spi_shift) & tick & ~second_half;
   assign trail_edge = (state == spi_shift) & tick & second_half;

   // cpha 0: sample leading, change trailing
   // cpha 1: change leading (first bit already out), sample trailing
   assign sample  = cfg.cpha ? trail_edge : lead_edge;
   assign advance = cfg.cpha ? (lead_edge & (bit_cnt != 3'd0)) : trail_edge;

   assign tx_pop  = (state == spi_idle) & cfg.spi_en & tx_nempty;
   assign ss_n    = (state == spi_idle);
   assign mosi    = cfg.lsbfirst ? tx_sr[0] : tx_sr[7];
   assign rx_byte = rx_sr; // stable until the next shift state

   // ################################################
   // frame FSM
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state       <= spi_idle;
         div_cnt     <= '0;
         bit_cnt     <= '0;
         second_half <= 1'b0;
         sclk        <= 1'b0;  // cpol resets to 0
         rx_access   <= 1'b0;
      end
      else
      begin
         rx_access <= 1'b0;
         if ((state == spi_idle) || tick)
            div_cnt <= '0;
         else
            div_cnt <= div_cnt + 8'd1;
         case (state)
            spi_idle :
            begin
               sclk        <= cfg.cpol; // park at idle level
               bit_cnt     <= '0;
               second_half <= 1'b0;
               if (tx_pop)
                  state <= spi_setup;
            end
            spi_setup :
            begin
               if (tick)
                  state <= spi_shift;
            end
            spi_shift :
            begin
               if (tick)
               begin
                  sclk        <= ~sclk;
                  second_half <= ~second_half;
                  if (second_half) // trailing edge ends a bit
                  begin
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7)
                        state <= spi_hold;
                  end
               end
            end
            spi_hold :
            begin
               if (tick)
               begin
                  state     <= spi_idle;
                  rx_access <= 1'b1; // byte complete
               end
            end
         endcase
      end
   end

   // ################################################
   // shift registers
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         tx_sr <= '0; // keeps mosi defined out of reset
      else if (tx_pop)
         tx_sr <= tx_byte;
      else if (advance)
         tx_sr <= cfg.lsbfirst ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};
   end

   // rx fills from the same end the tx side empties
   always_ff @(posedge clk)
   begin
      if (sample)
         rx_sr <= cfg.lsbfirst ? {miso, rx_sr[7:1]} : {rx_sr[6:0], miso};
   end

endmodule

//--- source/spi_queue.sv
/* synchronous FIFO with a type parameter for the entry
   head is shown combinationally, push and pop may share a cycle */
`timescale 1ns/1ps

module spi_queue #(
   parameter type entry_t = logic [7:0], // payload type
   parameter int  depth   = 4            // number of entries
) (
   input  logic   clk,
   input  logic   nreset,
   input  logic   push,
   input  entry_t din,
   input  logic   pop,
   output entry_t dout,   // head entry
   output logic   nempty,
   output logic   full
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   entry_t           mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             wr_en;
   logic             rd_en;

   assign wr_en = push & ~full; // overflow dropped
   assign rd_en = pop & nempty; // underflow ignored

   // ################################################
   // pointers and fill count
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10   : count <= count + 1'b1;
            2'b01   : count <= count - 1'b1;
            default : count <= count; // both or neither
         endcase
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= din;
   end

   assign dout   = mem[rd_ptr];
   assign nempty = (count != '0);
   assign full   = (count == cnt_w'(depth));

endmodule

//--- source/spi_master_pkg.sv
/* spi master shared types
   emesh packet, engine configuration, status register and engine state */
`include "spi_master_macros.svh"

package spi_master_pkg;

   // ################################################
   // emesh packet, 104 bits, write bit on top
   // ################################################
   typedef struct packed {
      logic              write;    // 1 = write, responses always set it
      logic [1:0]        datamode; // access size, copied to reply
      logic [4:0]        ctrlmode; // copied to reply
      logic [`SPI_AW-1:0] dstaddr; // low 6 bits select the register
      logic [`SPI_AW-1:0] srcaddr; // reply goes back here
      logic [31:0]       data;
   } emesh_packet_t;

   // config handed from register file to shift engine
   typedef struct packed {
      logic       spi_en;   // hw_en and not the disable bit
      logic       cpol;     // sclk idle level
      logic       cpha;     // 1 = sample on trailing edge
      logic       lsbfirst; // bit order on the wire
      logic [7:0] clkdiv;   // half period is clkdiv+1 cycles
   } spi_cfg_t;

   // status register layout
   typedef struct packed {
      logic [4:0] rsvd;
      logic       tx_nempty; // bit 2
      logic       busy;      // bit 1, engine not idle
      logic       rx_done;   // bit 0, sticky until written
   } spi_status_t;

   // shift engine states, anything but idle counts as busy
   typedef enum logic [1:0] {
      spi_idle  = 2'b00,
      spi_setup = 2'b01, // ss_n low, first bit on mosi
      spi_shift = 2'b10, // 16 sclk edges
      spi_hold  = 2'b11  // last half period before ss_n rises
   } spi_state_t;

endpackage

//--- include/spi_master_macros.svh
/* spi master register map and sizing
   register offsets, reset divider, queue depths and bus widths */
`ifndef SPI_MASTER_MACROS_SVH
`define SPI_MASTER_MACROS_SVH

// ################################################
// register offsets, decoded from dstaddr[5:0]
// ################################################
`define SPI_CONFIG       6'h00 // enables, polarity, phase, bit order
`define SPI_STATUS       6'h01 // rx flag, busy, tx queue not empty
`define SPI_CLKDIV       6'h02 // sclk half period minus one
`define SPI_CMD          6'h03 // reserved, no command register
`define SPI_TX           6'h08 // push one byte to the tx queue
`define SPI_RX0          6'h10 // rx shift register, low word
`define SPI_RX1          6'h11 // rx shift register, high word

// reset and sizing
`define SPI_CLKDIV_RESET 8'd1
`define SPI_TX_DEPTH     8 // bytes
`define SPI_RSP_DEPTH    4 // response packets

// emesh bus
`define SPI_AW           32
`define SPI_PW           104
`define SPI_READ_MISS    32'hdead_beef // unmapped read data

`endif
